// ==== files.f ====
source/icache_pkg.sv
source/tagged_memory.sv
source/icache.sv
source/fetch_stage.sv
source/fetch_top.sv
sim/fetch_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = fetch_tb
FILELIST = files.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT     = --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	$(SIM) $(LINT) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb
    import icache_pkg::*;
();

    localparam int              MEM_LATENCY   = 4;
    localparam int              MEM_BLOCKS    = 256;
    localparam logic [XLEN-1:0] RESET_PC      = '0;
    localparam int              CLK_PERIOD    = 4;                  // ns
    localparam int              PROGRAM_WORDS = MEM_BLOCKS * 2;     // two words per block
    localparam int              WORD_AW       = $clog2(PROGRAM_WORDS);
    localparam int              SEQ_FETCHES   = 40;
    localparam int              RANDOM_CYCLES = 300;
    localparam int              ROUNDS        = 4;                  // refetch and conflict rounds
    localparam int              TOTAL_FETCHES = SEQ_FETCHES + RANDOM_CYCLES + ROUNDS * 8 + 8;
    localparam int              WAIT_LIMIT    = 4 * (MEM_LATENCY + 4); // cycles to see a packet
    localparam int              WATCHDOG_NS   =
        (TOTAL_FETCHES * (MEM_LATENCY + 4) + PROGRAM_WORDS + 200) * CLK_PERIOD;

    logic            clock;
    logic            reset;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic            load_enable;
    logic [XLEN-1:0] load_addr;
    logic [XLEN-1:0] load_data;
    fetch_packet_t   fetch_packet;

    logic [XLEN-1:0] mem_model [PROGRAM_WORDS];  // program as loaded
    logic [XLEN-1:0] model_pc;                   // where the fetch stage should be
    logic            seen_valid;                 // last sampled packet
    logic [XLEN-1:0] seen_pc;
    integer          seed;
    int              error_count;
    int              tests_passed;
    int              checked;                    // valid packets in the current test

    fetch_top #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_BLOCKS (MEM_BLOCKS),
        .RESET_PC   (RESET_PC)
    ) dut_i (
        .clock         (clock),
        .reset         (reset),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .load_enable   (load_enable),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .fetch_packet  (fetch_packet)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, fetch stream stopped making progress", $time);
        $display("Errors found");
        $finish;
    end

    // word-aligned target in the lower 1 KB of program
    function automatic logic [XLEN-1:0] random_target();
        return ({$random(seed)} % (PROGRAM_WORDS / 2)) * 4;
    endfunction

    task automatic check_packet();
        seen_valid = fetch_packet.valid;
        seen_pc    = fetch_packet.pc;
        if (fetch_packet.valid) begin
            checked++;
            assert (fetch_packet.pc == model_pc) else begin
                $display("Mismatch at %0t: pc 0x%08h, model expects 0x%08h",
                         $time, fetch_packet.pc, model_pc);
                error_count++;
            end
            assert (fetch_packet.instruction == mem_model[model_pc[2 +: WORD_AW]]) else begin
                $display("Mismatch at %0t: instruction 0x%08h at pc 0x%08h, model 0x%08h",
                         $time, fetch_packet.instruction, model_pc,
                         mem_model[model_pc[2 +: WORD_AW]]);
                error_count++;
            end
        end
    endtask

    // sample at the falling edge, then drive this cycle's redirect
    task automatic run_cycle(input logic take_redirect, input logic [XLEN-1:0] target);
        @(negedge clock);
        check_packet();
        redirect_valid = take_redirect;
        redirect_pc    = target;
        if (take_redirect) begin
            model_pc = target;                       // redirect beats the step
        end else if (seen_valid) begin
            model_pc = model_pc + 4;
        end
    endtask

    task automatic wait_for_pc(input logic [XLEN-1:0] target);
        int n;
        n = 0;
        do begin
            run_cycle(1'b0, '0);
            n++;
        end while (!(seen_valid && seen_pc == target) && n < WAIT_LIMIT);
        assert (seen_valid && seen_pc == target) else begin
            $display("no valid packet at pc 0x%08h within %0d cycles", target, WAIT_LIMIT);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset          = 1'b1;
        redirect_valid = 1'b0;
        repeat (4) @(negedge clock);
        reset    = 1'b0;
        model_pc = RESET_PC;
    endtask

    task automatic load_program();
        for (int i = 0; i < PROGRAM_WORDS; i++) begin
            @(negedge clock);
            mem_model[i] = $random(seed);
            load_enable  = 1'b1;
            load_addr    = i * 4;                    // byte address of the word
            load_data    = mem_model[i];
        end
        @(negedge clock);
        load_enable = 1'b0;
    endtask

    // jump to an address; after the first visit the line must have been evicted
    task automatic visit(input logic [XLEN-1:0] target, input logic expect_miss);
        run_cycle(1'b1, target);
        if (expect_miss) begin
            run_cycle(1'b0, '0);
            assert (!seen_valid) else begin
                $display("0x%08h hit although its line held the other tag", target);
                error_count++;
            end
        end
        wait_for_pc(target);
    endtask

    task automatic report_test(input int number, input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %0d %s: pass, %0d packets checked", number, name, checked);
        end else begin
            $display("test %0d %s: FAIL, %0d errors", number, name, error_count - errors_before);
        end
    endtask

    initial begin
        int              errors_before;
        int              idle;
        logic [XLEN-1:0] addr_a;
        logic [XLEN-1:0] addr_b;
        seed           = 32'hc6ca;
        reset          = 1'b1;                       // held through program load
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        load_enable    = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        error_count    = 0;
        tests_passed   = 0;
        checked        = 0;
        model_pc       = RESET_PC;
        seen_valid     = 1'b0;
        seen_pc        = '0;
        load_program();
        apply_reset();

        errors_before = error_count;
        checked       = 0;
        while (checked < SEQ_FETCHES) begin
            run_cycle(1'b0, '0);
        end
        report_test(1, "sequential fetch", errors_before);

        errors_before = error_count;
        checked       = 0;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            if (($random(seed) & 7) == 0) begin
                run_cycle(1'b1, random_target());    // often lands mid-miss
            end else begin
                run_cycle(1'b0, '0);
            end
        end
        report_test(2, "random redirects", errors_before);

        errors_before = error_count;
        checked       = 0;
        for (int r = 0; r < ROUNDS; r++) begin
            addr_a = random_target() & ~32'h7;       // block aligned
            visit(addr_a, 1'b0);
            run_cycle(1'b0, '0);                     // step to the next word
            run_cycle(1'b1, addr_a);                 // back again
            run_cycle(1'b0, '0);
            assert (seen_valid && seen_pc == addr_a) else begin
                $display("refetch of 0x%08h missed, expected a hit after the redirect", addr_a);
                error_count++;
            end
        end
        report_test(3, "refetch of loaded lines", errors_before);

        errors_before = error_count;
        checked       = 0;
        addr_a        = 32'h0000_0140;
        addr_b        = addr_a + ICACHE_LINES * 8;   // same index, next tag
        visit(addr_a, 1'b0);
        for (int r = 0; r < ROUNDS; r++) begin
            visit(addr_b, 1'b1);
            visit(addr_a, 1'b1);
        end
        report_test(4, "conflict eviction", errors_before);

        errors_before = error_count;
        checked       = 0;
        visit(RESET_PC, 1'b0);                       // reset pc line cached before reset
        run_cycle(1'b1, random_target());
        repeat (3) run_cycle(1'b0, '0);
        apply_reset();
        idle = 0;
        run_cycle(1'b0, '0);
        assert (seen_pc == RESET_PC) else begin
            $display("Mismatch at %0t: pc 0x%08h after reset, expected 0x%08h",
                     $time, seen_pc, RESET_PC);
            error_count++;
        end
        while (!seen_valid && idle < WAIT_LIMIT) begin
            idle++;
            run_cycle(1'b0, '0);
        end
        assert (seen_valid && idle >= MEM_LATENCY + 1) else begin
            $display("fetch valid after reset came after %0d idle cycles, need at least %0d",
                     idle, MEM_LATENCY + 1);
            error_count++;
        end
        report_test(5, "reset mid-run", errors_before);

        $display("%0d of 5 tests passed, %0d errors", tests_passed, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import icache_pkg::*;
#(
    parameter int              MEM_LATENCY = 4,
    parameter int              MEM_BLOCKS  = 256,
    parameter logic [XLEN-1:0] RESET_PC    = '0
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            redirect_valid,
    input  logic [XLEN-1:0] redirect_pc,
    input  logic            load_enable,     // program loader port
    input  logic [XLEN-1:0] load_addr,
    input  logic [XLEN-1:0] load_data,
    output fetch_packet_t   fetch_packet
);

    icache_addr_t    fetch_addr;    // pc into the cache
    logic [XLEN-1:0] instruction;
    logic            hit;
    mem_req_t        mem_req;       // cache miss loads
    mem_rsp_t        mem_rsp;       // tags and returning blocks

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_stage_i (
        .clock         (clock),
        .reset         (reset),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .instruction   (instruction),
        .hit           (hit),
        .fetch_addr    (fetch_addr),
        .fetch_packet  (fetch_packet)
    );

    icache icache_i (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .mem_rsp    (mem_rsp),
        .instruction(instruction),
        .hit        (hit),
        .mem_req    (mem_req)
    );

    tagged_memory #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_BLOCKS (MEM_BLOCKS)
    ) tagged_memory_i (
        .clock      (clock),
        .reset      (reset),
        .mem_req    (mem_req),
        .load_enable(load_enable),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .mem_rsp    (mem_rsp)
    );

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import icache_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0    // first fetch address
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            redirect_valid,  // from outside, no prediction here
    input  logic [XLEN-1:0] redirect_pc,
    input  logic [XLEN-1:0] instruction,     // from the cache
    input  logic            hit,
    output icache_addr_t    fetch_addr,
    output fetch_packet_t   fetch_packet
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    // redirect wins over the sequential step
    always_comb begin
        pc_next = pc;                                   // hold while missing
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (hit) begin
            pc_next = pc + XLEN'(4);                    // one instruction per hit
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign fetch_addr = icache_addr_t'(pc);             // pc is the lookup address

    // packet valid in the hit cycle
    assign fetch_packet.pc          = pc;
    assign fetch_packet.instruction = instruction;
    assign fetch_packet.valid       = hit;

endmodule

// ==== source/icache.sv ====
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  icache_addr_t    fetch_addr,   // pc from the fetch stage
    input  mem_rsp_t        mem_rsp,
    output logic [XLEN-1:0] instruction,
    output logic            hit,
    output mem_req_t        mem_req
);

    // line storage, valid bits are the only part under reset
    logic [ICACHE_LINES-1:0] line_valid;
    logic [TAG_BITS-1:0]     line_tag  [ICACHE_LINES];
    cache_block_t            line_data [ICACHE_LINES];

    // block address seen last cycle
    logic [TAG_BITS-1:0]     last_tag;
    logic [INDEX_BITS-1:0]   last_index;
    logic                    last_seen;      // low right after reset

    logic                    miss_outstanding; // load goes out next cycle
    mem_tag_t                pending_tag;      // tag of our in-flight load, 0 if none

    logic                    addr_changed;
    logic                    miss_next;
    logic                    fill_enable;
    logic                    issue_load;
    cache_block_t            sel_block;

    // combinational lookup
    assign sel_block   = line_data[fetch_addr.index];
    assign instruction = sel_block.words[fetch_addr.offset[2]];   // word select by addr bit 2
    assign hit         = line_valid[fetch_addr.index] &&
                         (line_tag[fetch_addr.index] == fetch_addr.tag);

    // a new block address restarts miss handling
    assign addr_changed = !last_seen ||
                          (fetch_addr.tag != last_tag) ||
                          (fetch_addr.index != last_index);

    // new address: miss if not present; else keep waiting until a tag comes back
    assign miss_next = addr_changed ? !hit
                                    : (miss_outstanding && (mem_rsp.response_tag == '0));

    assign issue_load = miss_outstanding && !addr_changed;      // address held for a full cycle

    // only our own tag fills; a changing address has already given it up
    assign fill_enable = (pending_tag != '0) &&
                         (mem_rsp.data_tag == pending_tag) &&
                         !addr_changed;

    assign mem_req.command = issue_load ? MEM_LOAD : MEM_NONE;
    assign mem_req.addr    = {fetch_addr.tag, fetch_addr.index, {OFFSET_BITS{1'b0}}};

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid       <= '0;               // all lines invalid
            last_tag         <= '0;
            last_index       <= '0;
            last_seen        <= 1'b0;             // forces a lookup on the first cycle
            miss_outstanding <= 1'b0;
            pending_tag      <= '0;
        end else begin
            last_tag         <= fetch_addr.tag;
            last_index       <= fetch_addr.index;
            last_seen        <= 1'b1;
            miss_outstanding <= miss_next;

            if (addr_changed) begin
                pending_tag <= '0;                                // stale response is dropped
            end else if (issue_load) begin
                pending_tag <= mem_rsp.response_tag;              // capture issued tag
            end else if (fill_enable) begin
                pending_tag <= '0;                                // miss done
            end

            if (fill_enable) begin
                line_valid[fetch_addr.index] <= 1'b1;
            end
        end
    end

    // line payload
    always_ff @(posedge clock) begin
        if (fill_enable) begin
            line_tag[fetch_addr.index]  <= fetch_addr.tag;
            line_data[fetch_addr.index] <= mem_rsp.data;
        end
    end

endmodule

// ==== source/tagged_memory.sv ====
`timescale 1ns/1ps

module tagged_memory
    import icache_pkg::*;
#(
    parameter int MEM_LATENCY = 4,      // response delay in cycles, 1 or more
    parameter int MEM_BLOCKS  = 256     // 64-bit blocks
) (
    input  logic            clock,
    input  logic            reset,
    input  mem_req_t        mem_req,
    input  logic            load_enable,   // program loader strobe
    input  logic [XLEN-1:0] load_addr,     // byte address of the word
    input  logic [XLEN-1:0] load_data,
    output mem_rsp_t        mem_rsp
);

    localparam int BLOCK_AW = (MEM_BLOCKS > 1) ? $clog2(MEM_BLOCKS) : 1;

    cache_block_t        blocks [MEM_BLOCKS];         // backing store

    mem_tag_t            next_tag;                    // tag handed to the next load
    mem_tag_t            pipe_tag  [MEM_LATENCY];     // in-flight tags, 0 is an empty slot
    cache_block_t        pipe_data [MEM_LATENCY];     // blocks travelling with them

    logic [BLOCK_AW-1:0] read_block;
    logic [BLOCK_AW-1:0] write_block;
    logic                issue;

    assign issue       = (mem_req.command == MEM_LOAD);   // every load is accepted
    assign read_block  = mem_req.addr[OFFSET_BITS +: BLOCK_AW];
    assign write_block = load_addr[OFFSET_BITS +: BLOCK_AW];

    // same-cycle tag issue
    assign mem_rsp.response_tag = issue ? next_tag : '0;

    // end of the pipeline
    assign mem_rsp.data_tag = pipe_tag[MEM_LATENCY-1];
    assign mem_rsp.data     = pipe_data[MEM_LATENCY-1];

    // tag counter runs 1..15 and skips zero
    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= mem_tag_t'(1);
        end else if (issue) begin
            if (next_tag == '1) begin
                next_tag <= mem_tag_t'(1);      // wrap past zero
            end else begin
                next_tag <= next_tag + mem_tag_t'(1);
            end
        end
    end

    // tag shift pipeline, cleared on reset so no old block returns
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= mem_rsp.response_tag;    // zero when idle
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    // data shift pipeline
    always_ff @(posedge clock) begin
        pipe_data[0] <= blocks[read_block];         // read before any same-cycle write
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    // loader writes one 32-bit word per strobe
    always_ff @(posedge clock) begin
        if (load_enable) begin
            blocks[write_block].words[load_addr[2]] <= load_data;
        end
    end

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

    parameter int XLEN         = 32;                             // address and instruction width
    parameter int ICACHE_LINES = 32;                             // direct-mapped lines
    parameter int OFFSET_BITS  = 3;                              // 8-byte blocks
    parameter int INDEX_BITS   = $clog2(ICACHE_LINES);           // 5 bits of line index
    parameter int TAG_BITS     = XLEN - INDEX_BITS - OFFSET_BITS; // 24 bits left for the tag
    parameter int MEM_TAG_BITS = 4;                              // transaction tag width

    // one 64-bit block, seen at several granularities
    typedef union packed {
        logic [63:0]      double;
        logic [1:0][31:0] words;                                 // word 1 is the upper half
        logic [3:0][15:0] halves;
        logic [7:0][7:0]  bytes;
    } cache_block_t;

    // address split for the direct-mapped cache
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;                          // bit 2 picks the word
    } icache_addr_t;

    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;                  // zero means no transaction

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2                                         // reserved, no data cache
    } mem_command_t;

    // cache to memory
    typedef struct packed {
        mem_command_t    command;
        logic [XLEN-1:0] addr;                                   // block aligned
    } mem_req_t;

    // memory to cache
    typedef struct packed {
        mem_tag_t     response_tag;                              // tag issued this cycle
        mem_tag_t     data_tag;                                  // tag of returning block
        cache_block_t data;
    } mem_rsp_t;

    // fetch stage to top-level outputs
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instruction;
        logic            valid;
    } fetch_packet_t;

endpackage
